// File: Bender.yml
package:
  name: output_gate

sources:
  # RTL in compile order
  - files:
      - hdl/gate_pkg.sv
      - hdl/stage_reg.sv
      - hdl/term_decode.sv
      - hdl/mac_execute.sv
      - hdl/logistic_result.sv
      - hdl/output_gate_top.sv

  # Testbench
  - target: test
    include_dirs:
      - verif
    files:
      - verif/gate_tb.sv

// File: hdl/gate_pkg.sv
`default_nettype none

package gate_pkg;

  ////////////////////////////////////////
  // Fixed point format
  ////////////////////////////////////////

  localparam int DATA_W = 16;  // Q8.8 operand
  localparam int FRAC_W = 8;   // Fraction bits
  localparam int ACC_W  = 32;  // Accumulator, wraps on overflow

  localparam logic signed [DATA_W-1:0] FIX_ONE  = 256;  // 1.0
  localparam logic signed [DATA_W-1:0] FIX_HALF = 128;  // 0.5

  ////////////////////////////////////////
  // Term and stage payloads
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    TERM_MAC    = 2'd0,  // acc += a*b
    TERM_BIAS   = 2'd1,  // acc += a
    TERM_FINISH = 2'd2,  // acc += a*b, then emit
    TERM_CLEAR  = 2'd3   // acc = 0, nothing emitted
  } term_kind_t;

  // Input channel word
  typedef struct packed {
    term_kind_t               kind;
    logic signed [DATA_W-1:0] a;
    logic signed [DATA_W-1:0] b;
  } term_t;

  // Decode to execute
  typedef struct packed {
    logic                     clear;   // Zero the sum
    logic                     finish;  // Emit after update
    logic signed [DATA_W-1:0] a;
    logic signed [DATA_W-1:0] b;
  } exec_op_t;

  // Execute to result
  typedef struct packed {
    logic signed [ACC_W-1:0] sum;
    logic                    sat;  // Sum outside 16-bit range
  } pre_act_t;

  // Output channel word
  typedef struct packed {
    logic        [DATA_W-1:0] value;  // 0 .. FIX_ONE
    logic signed [DATA_W-1:0] pre;    // Clipped pre-activation
    logic                     sat;
  } gate_out_t;

endpackage

`default_nettype wire

// File: hdl/logistic_result.sv
`timescale 1ns/1ps
`default_nettype none

module logistic_result (
  input  logic                CLK,
  input  logic                RST,

  // Pre-activation from execute
  input  logic                pre_valid,
  input  gate_pkg::pre_act_t  pre,
  output logic                pre_ready,

  // Four-phase result output
  output logic                out_req,
  output gate_pkg::gate_out_t out_data,
  input  logic                out_ack
);

  import gate_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE    = 2'd0,  // Handshake fully low
    S_REQ     = 2'd1,  // Req high, waiting for ack
    S_ACK_LOW = 2'd2   // Req dropped, waiting for ack low
  } tx_state_t;

  tx_state_t                state;
  logic signed [DATA_W-1:0] pre_clip;  // Saturated sum
  logic signed [DATA_W-1:0] slope;     // pre/4
  logic signed [DATA_W-1:0] hs;        // Before clamping
  logic        [DATA_W-1:0] value;     // Hard sigmoid
  logic                     take;

  assign pre_ready = (state == S_IDLE);
  assign take      = pre_valid && pre_ready;

  ////////////////////////////////////////
  // Saturation and hard sigmoid
  ////////////////////////////////////////

  always_comb begin
    if (pre.sat) begin
      // Clip toward the sign of the sum
      pre_clip = pre.sum[ACC_W-1] ? {1'b1, {(DATA_W-1){1'b0}}}
                                  : {1'b0, {(DATA_W-1){1'b1}}};
    end else begin
      pre_clip = pre.sum[DATA_W-1:0];
    end
  end

  assign slope = pre_clip >>> 2;    // Slope 1/4
  assign hs    = slope + FIX_HALF;  // Centered on 0.5, cannot overflow

  always_comb begin
    if (hs < 0) begin
      value = '0;
    end else if (hs > FIX_ONE) begin
      value = FIX_ONE;
    end else begin
      value = hs;
    end
  end

  ////////////////////////////////////////
  // Four-phase sender
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= S_IDLE;
      out_req <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (take) begin
            out_req <= 1'b1;  // Data registered on the same edge
            state   <= S_REQ;
          end
        end
        S_REQ: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= S_ACK_LOW;
          end
        end
        S_ACK_LOW: if (!out_ack) state <= S_IDLE;
        default:   state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (take) begin
      out_data.value <= value;
      out_data.pre   <= pre_clip;
      out_data.sat   <= pre.sat;
    end
  end

endmodule

`default_nettype wire

// File: hdl/mac_execute.sv
`timescale 1ns/1ps
`default_nettype none

module mac_execute (
  input  logic               CLK,
  input  logic               RST,

  // Ops from decode
  input  logic               op_valid,
  input  gate_pkg::exec_op_t op,
  output logic               op_ready,

  // Pre-activation to result
  output logic               pre_valid,
  output gate_pkg::pre_act_t pre,
  input  logic               pre_ready
);

  import gate_pkg::*;

  logic signed [ACC_W-1:0]  acc;           // Running sum, Q8.8 in 32 bits
  logic signed [ACC_W-1:0]  product;       // a*b, Q16.16
  logic signed [ACC_W-1:0]  scaled;        // Back to Q8.8
  logic signed [ACC_W-1:0]  acc_next;
  logic        [ACC_W-DATA_W:0] top_bits;  // Sign bits above the 16-bit range
  logic                     out_of_range;
  logic                     fire;          // Op consumed this edge
  logic                     emit;          // Finish consumed this edge

  // Hold off every op while a finished sum is still waiting
  assign op_ready = !pre_valid || pre_ready;
  assign fire     = op_valid && op_ready;
  assign emit     = fire && op.finish;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  assign product  = $signed(op.a) * $signed(op.b);
  assign scaled   = product >>> FRAC_W;                // Arithmetic, keeps sign
  assign acc_next = op.clear ? '0 : acc + scaled;      // Wraps at ACC_W

  // In range only when all bits from bit 15 up agree
  assign top_bits     = acc_next[ACC_W-1:DATA_W-1];
  assign out_of_range = !((&top_bits) || !(|top_bits));

  ////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc <= '0;
    end else if (fire) begin
      acc <= op.finish ? '0 : acc_next;  // Fresh sum after each finish
    end
  end

  // Result slot
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pre_valid <= 1'b0;
    end else if (emit) begin
      pre_valid <= 1'b1;
    end else if (pre_ready) begin
      pre_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (emit) begin
      pre.sum <= acc_next;      // Includes the finishing product
      pre.sat <= out_of_range;
    end
  end

endmodule

`default_nettype wire

// File: hdl/output_gate_top.sv
`timescale 1ns/1ps
`default_nettype none

module output_gate_top (
  input  logic                CLK,
  input  logic                RST,

  // Term input, four-phase
  input  logic                in_req,
  input  gate_pkg::term_t     in_term,
  output logic                in_ack,

  // Gate result, four-phase
  output logic                out_req,
  output gate_pkg::gate_out_t out_data,
  input  logic                out_ack
);

  import gate_pkg::*;

  ////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////

  logic     dec_valid;  // Decode to op register
  logic     dec_ready;
  exec_op_t dec_op;

  logic     exe_valid;  // Op register to execute
  logic     exe_ready;
  exec_op_t exe_op;

  logic     acc_valid;  // Execute to pre register
  logic     acc_ready;
  pre_act_t acc_pre;

  logic     res_valid;  // Pre register to result
  logic     res_ready;
  pre_act_t res_pre;

  term_decode u_decode (
    .CLK      (CLK),
    .RST      (RST),
    .in_req   (in_req),
    .in_term  (in_term),
    .in_ack   (in_ack),
    .op_valid (dec_valid),
    .op       (dec_op),
    .op_ready (dec_ready)
  );

  stage_reg #(.payload_t(exec_op_t)) u_op_reg (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (dec_valid),
    .in_data   (dec_op),
    .in_ready  (dec_ready),
    .out_valid (exe_valid),
    .out_data  (exe_op),
    .out_ready (exe_ready)
  );

  mac_execute u_execute (
    .CLK       (CLK),
    .RST       (RST),
    .op_valid  (exe_valid),
    .op        (exe_op),
    .op_ready  (exe_ready),
    .pre_valid (acc_valid),
    .pre       (acc_pre),
    .pre_ready (acc_ready)
  );

  stage_reg #(.payload_t(pre_act_t)) u_pre_reg (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (acc_valid),
    .in_data   (acc_pre),
    .in_ready  (acc_ready),
    .out_valid (res_valid),
    .out_data  (res_pre),
    .out_ready (res_ready)
  );

  logistic_result u_result (
    .CLK       (CLK),
    .RST       (RST),
    .pre_valid (res_valid),
    .pre       (res_pre),
    .pre_ready (res_ready),
    .out_req   (out_req),
    .out_data  (out_data),
    .out_ack   (out_ack)
  );

endmodule

`default_nettype wire

// File: hdl/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     RST,

  // Upstream side
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,

  // Downstream side
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  logic     valid_q;  // Entry occupied
  payload_t data_q;   // Held item

  // Free slot, or the held item leaves this edge
  assign in_ready  = !valid_q || out_ready;

  assign out_valid = valid_q;
  assign out_data  = data_q;

  ////////////////////////////////////////
  // Occupancy
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;  // Refill or drain
    end
  end

  ////////////////////////////////////////
  // Payload
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;  // Capture on transfer only
    end
  end

endmodule

`default_nettype wire

// File: hdl/term_decode.sv
`timescale 1ns/1ps
`default_nettype none

module term_decode (
  input  logic               CLK,
  input  logic               RST,

  // Four-phase term input
  input  logic               in_req,
  input  gate_pkg::term_t    in_term,
  output logic               in_ack,

  // Uniform op to execute
  output logic               op_valid,
  output gate_pkg::exec_op_t op,
  input  logic               op_ready
);

  import gate_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE     = 2'd0,  // Waiting for req
    S_ACKED    = 2'd1,  // Ack high, waiting for req low
    S_WAIT_LOW = 2'd2   // Ack just dropped
  } rx_state_t;

  rx_state_t state;
  exec_op_t  op_next;    // Decoded term
  logic      slot_free;  // Output slot can take a new op
  logic      capture;    // Accept the term this edge

  assign slot_free = !op_valid || op_ready;
  assign capture   = (state == S_IDLE) && in_req && slot_free;

  ////////////////////////////////////////
  // Term to MAC op mapping
  ////////////////////////////////////////

  always_comb begin
    op_next.clear  = 1'b0;
    op_next.finish = 1'b0;
    op_next.a      = in_term.a;
    op_next.b      = in_term.b;
    case (in_term.kind)
      TERM_BIAS:   op_next.b      = FIX_ONE;  // a*1.0 passes a through
      TERM_FINISH: op_next.finish = 1'b1;
      TERM_CLEAR: begin
        op_next.clear = 1'b1;
        op_next.a     = '0;  // Product stays zero
        op_next.b     = '0;
      end
      default: ;  // Plain MAC
    endcase
  end

  ////////////////////////////////////////
  // Four-phase receiver
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= S_IDLE;
      in_ack <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (capture) begin
            in_ack <= 1'b1;
            state  <= S_ACKED;
          end
        end
        S_ACKED: begin
          if (!in_req) begin  // Host released
            in_ack <= 1'b0;
            state  <= S_WAIT_LOW;
          end
        end
        S_WAIT_LOW: state <= S_IDLE;  // Return to zero complete
        default:    state <= S_IDLE;
      endcase
    end
  end

  // Output slot
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      op_valid <= 1'b0;
    end else if (capture) begin
      op_valid <= 1'b1;
    end else if (op_ready) begin
      op_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (capture) begin
      op <= op_next;
    end
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+verif
hdl/gate_pkg.sv
hdl/stage_reg.sv
hdl/term_decode.sv
hdl/mac_execute.sv
hdl/logistic_result.sv
hdl/output_gate_top.sv
verif/gate_tb.sv

// File: verif/gate_ref.svh
`ifndef GATE_REF_SVH
`define GATE_REF_SVH

////////////////////////////////////////
// Reference model of the gate element
////////////////////////////////////////

// Applies one term to the model sum, returns 1 when a result is owed
function automatic bit ref_step(input term_t t, inout logic signed [ACC_W-1:0] acc,
                                output gate_out_t want);
  logic signed [ACC_W-1:0] a32;
  logic signed [ACC_W-1:0] b32;
  logic signed [ACC_W-1:0] prod;  // Q8.8 product
  logic signed [ACC_W-1:0] sum;
  int                      clip;
  int                      v;
  ref_step = 1'b0;
  want     = '0;
  a32      = t.a;  // Sign extended
  b32      = t.b;
  prod     = (a32 * b32) >>> 8;
  case (t.kind)
    TERM_MAC:   acc = acc + prod;
    TERM_BIAS:  acc = acc + a32;  // Bias enters unscaled
    TERM_CLEAR: acc = '0;
    default: begin
      sum = acc + prod;  // Finishing product counts
      acc = '0;
      want.sat = (sum > 32767) || (sum < -32768);
      if (sum > 32767) begin
        clip = 32767;
      end else if (sum < -32768) begin
        clip = -32768;
      end else begin
        clip = sum;
      end
      v = (clip >>> 2) + 128;  // Hard sigmoid, slope 1/4 around 0.5
      if (v < 0) begin
        v = 0;
      end else if (v > 256) begin
        v = 256;
      end
      want.pre   = clip[15:0];
      want.value = v[15:0];
      ref_step   = 1'b1;
    end
  endcase
endfunction

////////////////////////////////////////
// Field compares
////////////////////////////////////////

task automatic check_value(input gate_out_t got, input gate_out_t want);
  if (got.value !== want.value) begin
    abort_run($sformatf("Fail out_data.value got %h expected %h", got.value, want.value));
  end
endtask

task automatic check_pre(input gate_out_t got, input gate_out_t want);
  if (got.pre !== want.pre) begin
    abort_run($sformatf("Fail out_data.pre got %h expected %h", got.pre, want.pre));
  end
endtask

task automatic check_sat(input gate_out_t got, input gate_out_t want);
  if (got.sat !== want.sat) begin
    abort_run($sformatf("Fail out_data.sat got %h expected %h", got.sat, want.sat));
  end
endtask

`endif

// File: verif/gate_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gate_tb;

  import gate_pkg::*;

  localparam int TIMEOUT = 1000;  // Cycles allowed per wait

  logic      CLK;
  logic      RST;
  logic      in_req;
  term_t     in_term;
  logic      in_ack;
  logic      out_req;
  gate_out_t out_data;
  logic      out_ack;

  gate_out_t               expected[$];   // Results still owed by the DUT
  logic signed [ACC_W-1:0] model_acc;     // Reference running sum
  bit                      long_ack;      // Slow responder
  int                      ack_wait_max;  // Longest in_ack stall seen

  output_gate_top dut0 (
    .CLK      (CLK),
    .RST      (RST),
    .in_req   (in_req),
    .in_term  (in_term),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_data (out_data),
    .out_ack  (out_ack)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  `include "gate_ref.svh"

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;  // 4 ns period
  end

  ////////////////////////////////////////
  // Host side
  ////////////////////////////////////////

  function automatic logic signed [DATA_W-1:0] rand_operand();
    int r;
    r = $urandom_range(1023, 0);
    rand_operand = 16'(r - 512);  // About -2.0 .. 2.0
  endfunction

  // Four-phase send of one term
  task automatic send_term(input term_kind_t kind, input logic signed [DATA_W-1:0] a,
                           input logic signed [DATA_W-1:0] b);
    term_t     t;
    gate_out_t want;
    int        n;
    t.kind = kind;
    t.a    = a;
    t.b    = b;
    if (ref_step(t, model_acc, want)) begin
      expected.push_back(want);
    end
    @(negedge CLK);
    in_term = t;
    in_req  = 1'b1;
    n = 0;
    while (!in_ack) begin
      @(negedge CLK);
      n++;
      if (n > TIMEOUT) begin
        abort_run("Timed out waiting for in_ack to rise");
      end
    end
    if (n > ack_wait_max) begin
      ack_wait_max = n;
    end
    in_req = 1'b0;
    n = 0;
    while (in_ack) begin
      @(negedge CLK);
      n++;
      if (n > TIMEOUT) begin
        abort_run("Timed out waiting for in_ack to fall");
      end
    end
  endtask

  // W·x, K·r and U·h groups, bias, then finish
  task automatic send_random_gate();
    int n;
    for (int g = 0; g < 3; g++) begin
      n = $urandom_range(4, 1);
      repeat (n) send_term(TERM_MAC, rand_operand(), rand_operand());
    end
    send_term(TERM_BIAS, rand_operand(), 16'sd0);
    send_term(TERM_FINISH, rand_operand(), rand_operand());
  endtask

  ////////////////////////////////////////
  // Result side
  ////////////////////////////////////////

  initial begin : ack_responder
    int n;
    int d;
    out_ack = 1'b0;
    @(negedge RST);
    forever begin
      n = 0;
      while (!out_req) begin
        @(negedge CLK);
        if (expected.size() != 0) n++;  // Only count while a result is owed
        if (n > TIMEOUT) begin
          abort_run("Timed out waiting for out_req to rise");
        end
      end
      d = long_ack ? 30 : $urandom_range(5, 0);
      repeat (d) @(negedge CLK);
      out_ack = 1'b1;
      n = 0;
      while (out_req) begin
        @(negedge CLK);
        n++;
        if (n > TIMEOUT) begin
          abort_run("Timed out waiting for out_req to fall");
        end
      end
      d = long_ack ? 30 : $urandom_range(5, 0);
      repeat (d) @(negedge CLK);
      out_ack = 1'b0;
    end
  end

  initial begin : compare_results
    int        n;
    gate_out_t want;
    @(negedge RST);
    forever begin
      n = 0;
      while (!out_req) begin
        @(negedge CLK);
        if (expected.size() != 0) n++;
        if (n > TIMEOUT) begin
          abort_run("Timed out waiting for a result on out_req");
        end
      end
      if (expected.size() == 0) begin
        abort_run("out_req rose with no result expected");
      end
      want = expected.pop_front();
      check_value(out_data, want);  // Held stable while out_req is high
      check_pre(out_data, want);
      check_sat(out_data, want);
      n = 0;
      while (out_req) begin
        @(negedge CLK);
        n++;
        if (n > TIMEOUT) begin
          abort_run("Timed out waiting for out_req to drop after a result");
        end
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : main
    int n;
    void'($urandom(85382));
    RST          = 1'b1;
    in_req       = 1'b0;
    in_term      = '0;
    model_acc    = '0;
    long_ack     = 1'b0;
    ack_wait_max = 0;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    send_term(TERM_FINISH, 16'sh0180, 16'sh0040);  // 1.5 * 0.25 alone
    repeat (6) send_random_gate();

    // Saturation both ways
    send_term(TERM_MAC, 16'sh7f00, 16'sh7f00);
    send_term(TERM_FINISH, 16'sh7f00, 16'sh7f00);
    send_term(TERM_MAC, 16'sh8000, 16'sh7fff);
    send_term(TERM_FINISH, 16'sh8000, 16'sh7fff);

    // Clear drops everything before it
    send_term(TERM_MAC, 16'sh0300, 16'sh0200);
    send_term(TERM_BIAS, 16'sh0100, 16'sd0);
    send_term(TERM_CLEAR, 16'sh1234, 16'sh5678);
    send_term(TERM_MAC, 16'sh0080, 16'sh0100);
    send_term(TERM_FINISH, 16'shff80, 16'sh0040);

    // Slow out_ack backs up the pipe
    ack_wait_max = 0;
    long_ack     = 1'b1;
    repeat (8) send_term(TERM_FINISH, rand_operand(), rand_operand());
    if (ack_wait_max < 10) begin
      abort_run("in_ack was never withheld under a slow out_ack");
    end
    long_ack = 1'b0;

    n = 0;
    while (expected.size() != 0 || out_req || out_ack) begin
      @(negedge CLK);
      n++;
      if (n > TIMEOUT) begin
        abort_run("Timed out waiting for the last results to drain");
      end
    end
    repeat (20) @(negedge CLK);  // Window for a stray result
    if (expected.size() == 0 && !out_req) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      abort_run("Expected results still outstanding at the end of the test");
    end
  end

endmodule

`default_nettype wire
